/* files.f */
verilog/cpuPkg.sv
verilog/fetchUnit.sv
verilog/controlDecoder.sv
verilog/registerFile.sv
verilog/executeUnit.sv
verilog/mipsCore.sv
bench/mipsCoreAssert.sv
bench/mipsCoreTb.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - files:
      - verilog/cpuPkg.sv
      - verilog/fetchUnit.sv
      - verilog/controlDecoder.sv
      - verilog/registerFile.sv
      - verilog/executeUnit.sv
      - verilog/mipsCore.sv
  - target: simulation
    files:
      - bench/mipsCoreAssert.sv
      - bench/mipsCoreTb.sv

/* bench/mipsCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb;
	import cpuPkg::*;

	localparam int words = 64;
	localparam int period = 20;
	localparam int resetCycles = 16;

	logic clk = 1'b0;
	logic rstN;
	logic [xlen-1:0] instrAddr;
	logic [xlen-1:0] instrData;
	logic [xlen-1:0] dataAddr;
	logic [xlen-1:0] dataWrData;
	logic dataWe;
	logic [xlen-1:0] dataRdData;
	logic [xlen-1:0] rom [words];
	logic [xlen-1:0] dataMem [words];
	logic [regAddrW-1:0] wrDest [words]; // Register written by each ROM word
	logic [xlen-1:0] wrVal [words];
	logic [xlen-1:0] modelRegs [32];
	logic [xlen-1:0] storeVal [words]; // Expected stores by word address
	logic storeAllowed [words];
	logic written [words];
	logic [xlen-1:0] expNextPc;
	logic [xlen-1:0] donePc;
	logic regsEqual;
	logic [xlen-1:0] opA;
	logic [xlen-1:0] opB;
	logic [15:0] immS;
	logic [15:0] immZ;
	logic [4:0] sh;
	int progLen;
	int storeCount;
	int assertFails;
	int missing;

	mipsCore uut (.*);
	bind mipsCore mipsCoreAssert checks (.*);

	always #(period / 2) clk = ~clk;

	assign instrData = rom[instrAddr[7:2]];
	assign dataRdData = dataMem[dataAddr[7:2]];
	assign regsEqual = modelRegs[instrData[25:21]] == modelRegs[instrData[20:16]];

	always_comb begin
		expNextPc = instrAddr + 32'd4;
		if (instrData[31:26] == opJ) begin
			expNextPc = {expNextPc[31:28], instrData[25:0], 2'b00};
		end else if ((instrData[31:26] == opBeq && regsEqual) ||
				(instrData[31:26] == opBne && !regsEqual)) begin
			expNextPc = expNextPc + {{14{instrData[15]}}, instrData[15:0], 2'b00};
		end
	end

	always @(posedge clk) begin
		if (rstN) begin
			if (wrDest[instrAddr[7:2]] != '0) begin
				modelRegs[wrDest[instrAddr[7:2]]] <= wrVal[instrAddr[7:2]];
			end
			if (dataWe) begin
				dataMem[dataAddr[7:2]] <= dataWrData;
				written[dataAddr[7:2]] <= 1'b1;
				storeCount <= storeCount + 1;
			end
		end
	end

	function automatic logic [31:0] rWord(input logic [5:0] fn, input logic [4:0] rs,
			input logic [4:0] rt, input logic [4:0] shamt);
		return {opRType, rs, rt, 5'd3, shamt, fn};
	endfunction

	function automatic logic [31:0] iWord(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic emit(input logic [31:0] word, input logic [4:0] dest, input logic [31:0] value);
		rom[progLen] = word;
		wrDest[progLen] = dest;
		wrVal[progLen] = value;
		progLen++;
	endtask

	task automatic storeWord(input logic [4:0] rt, input int slot, input logic [31:0] value,
			input logic allowed);
		emit(iWord(opSw, 5'd0, rt, 16'(slot * 4)), 5'd0, 32'd0);
		storeVal[slot] = value;
		storeAllowed[slot] = allowed;
	endtask

	task automatic rTest(input logic [5:0] fn, input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] shamt, input logic [31:0] value, input int slot);
		emit(rWord(fn, rs, rt, shamt), 5'd3, value); // Result always in r3
		storeWord(5'd3, slot, value, 1'b1);
	endtask

	task automatic iTest(input logic [5:0] op, input logic [4:0] rs, input logic [15:0] imm,
			input logic [31:0] value, input int slot);
		emit(iWord(op, rs, 5'd3, imm), 5'd3, value);
		storeWord(5'd3, slot, value, 1'b1);
	endtask

	initial begin
		#1;
		#((progLen * 3 + resetCycles) * period);
		$display("Timeout: the core never reached its final jump");
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		rstN = 1'b0;
		progLen = 0;
		storeCount = 0;
		assertFails = 0;
		missing = 0;
		void'($urandom(32'h57a7_0efa));
		opA = $urandom();
		opB = $urandom();
		immS = 16'($urandom());
		immZ = 16'($urandom());
		sh = 5'($urandom());
		for (int i = 0; i < words; i++) begin
			dataMem[i] = 32'hc0de_0000 ^ 32'(i * 4);
			wrDest[i] = '0;
			wrVal[i] = '0;
			storeVal[i] = '0;
			storeAllowed[i] = 1'b0;
			written[i] = 1'b0;
		end
		for (int i = 0; i < 32; i++) begin
			modelRegs[i] = '0;
		end
		emit(iWord(opLui, 5'd0, 5'd1, opA[31:16]), 5'd1, {opA[31:16], 16'h0}); // r1 = opA
		emit(iWord(opOri, 5'd1, 5'd1, opA[15:0]), 5'd1, opA);
		emit(iWord(opLui, 5'd0, 5'd2, opB[31:16]), 5'd2, {opB[31:16], 16'h0}); // r2 = opB
		emit(iWord(opOri, 5'd2, 5'd2, opB[15:0]), 5'd2, opB);
		rTest(fnAdd, 5'd1, 5'd2, 5'd0, opA + opB, 0);
		rTest(fnSub, 5'd1, 5'd2, 5'd0, opA - opB, 1);
		rTest(fnAnd, 5'd1, 5'd2, 5'd0, opA & opB, 2);
		rTest(fnOr, 5'd1, 5'd2, 5'd0, opA | opB, 3);
		rTest(fnXor, 5'd1, 5'd2, 5'd0, opA ^ opB, 4);
		rTest(fnNor, 5'd1, 5'd2, 5'd0, ~(opA | opB), 5);
		rTest(fnSlt, 5'd1, 5'd2, 5'd0, {31'd0, $signed(opA) < $signed(opB)}, 6);
		rTest(fnSll, 5'd0, 5'd2, sh, opB << sh, 7);
		iTest(opAddi, 5'd1, immS, opA + {{16{immS[15]}}, immS}, 8);
		iTest(opAndi, 5'd1, immZ, opA & {16'h0, immZ}, 9);
		iTest(opOri, 5'd1, immZ, opA | {16'h0, immZ}, 10);
		iTest(opLui, 5'd0, immZ, {immZ, 16'h0}, 11);
		emit(iWord(opLw, 5'd0, 5'd4, 16'd0), 5'd4, opA + opB); // Reload slot 0
		storeWord(5'd4, 12, opA + opB, 1'b1);
		emit(iWord(opAddi, 5'd1, 5'd0, immS), 5'd0, 32'd0); // Attempted r0 write
		storeWord(5'd0, 13, 32'd0, 1'b1);
		emit(iWord(opBeq, 5'd1, 5'd1, 16'd1), 5'd0, 32'd0);
		storeWord(5'd1, 14, opA, 1'b0); // Skipped by BEQ
		emit(iWord(opBne, 5'd1, 5'd1, 16'd1), 5'd0, 32'd0);
		storeWord(5'd1, 15, opA, 1'b1);
		emit({opJ, 26'(progLen + 2)}, 5'd0, 32'd0);
		storeWord(5'd1, 16, opA, 1'b0); // Skipped by J
		donePc = 32'(progLen * 4);
		emit({opJ, 26'(progLen)}, 5'd0, 32'd0);

		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		$display("Test reset: released after %0d cycles", resetCycles);
		while (instrAddr != donePc) begin
			@(negedge clk);
		end
		repeat (2) @(negedge clk); // A few turns of the self-jump
		$display("Test program: final jump reached after %0d stores", storeCount);
		for (int i = 0; i < words; i++) begin
			if (storeAllowed[i] && !written[i]) begin
				$display("The expected store to address %h was missing", 32'(i * 4));
				missing++;
			end
		end
		$display("Test completion: %0d stores missing", missing);
		$display("Totals: %0d stores, %0d assertion failures, %0d missing stores",
			storeCount, assertFails, missing);
		if (assertFails == 0 && missing == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* bench/mipsCoreAssert.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCoreAssert (
	input wire logic clk,
	input wire logic rstN,
	input wire logic [cpuPkg::xlen-1:0] instrAddr,
	input wire logic [cpuPkg::xlen-1:0] dataAddr,
	input wire logic [cpuPkg::xlen-1:0] dataWrData,
	input wire logic dataWe
);
	import cpuPkg::*;

	logic inRange;

	assign inRange = (dataAddr[xlen-1:8] == '0); // 64-word data memory

	resetHold: assert property (@(posedge clk) !rstN |-> instrAddr == resetPc && !dataWe)
		else begin
			$error("ERR %0t: in reset instrAddr %h dataWe %b", $time, instrAddr, dataWe);
			mipsCoreTb.assertFails = mipsCoreTb.assertFails + 1;
		end

	firstCycle: assert property (@(posedge clk) $rose(rstN) |-> instrAddr == resetPc && !dataWe)
		else begin
			$error("ERR %0t: first cycle instrAddr %h dataWe %b", $time, instrAddr, dataWe);
			mipsCoreTb.assertFails = mipsCoreTb.assertFails + 1;
		end

	pcStep: assert property (@(posedge clk) disable iff (!rstN)
			rstN |=> instrAddr == $past(mipsCoreTb.expNextPc))
		else begin
			$error("ERR %0t: next PC is %h", $time, instrAddr);
			mipsCoreTb.assertFails = mipsCoreTb.assertFails + 1;
		end

	storePlace: assert property (@(posedge clk) disable iff (!rstN)
			dataWe |-> inRange && mipsCoreTb.storeAllowed[dataAddr[7:2]])
		else begin
			$error("The core stored to address %h, which must not be written", dataAddr);
			mipsCoreTb.assertFails = mipsCoreTb.assertFails + 1;
		end

	storeValue: assert property (@(posedge clk) disable iff (!rstN)
			dataWe && inRange |-> dataWrData == mipsCoreTb.storeVal[dataAddr[7:2]])
		else begin
			$error("ERR %0t: store to %h wrote %h, expected %h", $time, dataAddr, dataWrData,
				mipsCoreTb.storeVal[dataAddr[7:2]]);
			mipsCoreTb.assertFails = mipsCoreTb.assertFails + 1;
		end

endmodule

`default_nettype wire

/* verilog/mipsCore.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCore (
	input wire logic clk,
	input wire logic rstN,
	output logic [cpuPkg::xlen-1:0] instrAddr,
	input wire logic [cpuPkg::xlen-1:0] instrData,
	output logic [cpuPkg::xlen-1:0] dataAddr,
	output logic [cpuPkg::xlen-1:0] dataWrData,
	output logic dataWe,
	input wire logic [cpuPkg::xlen-1:0] dataRdData
);
	import cpuPkg::*;

	instrWordT instr;
	logic [aluOpW-1:0] aluOp;
	logic aluSrcImm;
	logic signExt;
	logic regDstRd;
	logic regWe;
	logic memToReg;
	logic branchEq;
	logic branchNe;
	logic jump;
	logic [xlen-1:0] rsData;
	logic [xlen-1:0] rtData;
	logic [xlen-1:0] aluResult;
	logic takeBranch;
	logic [xlen-1:0] branchTarget;

	assign instr = instrData;
	assign dataAddr = aluResult;
	assign dataWrData = rtData; // SW stores rt

	fetchUnit fetch (
		.clk(clk),
		.rstN(rstN),
		.instr(instr),
		.takeBranch(takeBranch),
		.branchTarget(branchTarget),
		.jump(jump),
		.pc(instrAddr)
	);

	controlDecoder decode (
		.instr(instr),
		.aluOp(aluOp),
		.aluSrcImm(aluSrcImm),
		.signExt(signExt),
		.regDstRd(regDstRd),
		.regWe(regWe),
		.memToReg(memToReg),
		.memWe(dataWe),
		.branchEq(branchEq),
		.branchNe(branchNe),
		.jump(jump)
	);

	registerFile regs (
		.clk(clk),
		.rstN(rstN),
		.instr(instr),
		.regDstRd(regDstRd),
		.regWe(regWe),
		.memToReg(memToReg),
		.aluResult(aluResult),
		.loadData(dataRdData),
		.rsData(rsData),
		.rtData(rtData)
	);

	executeUnit execute (
		.instr(instr),
		.pc(instrAddr),
		.rsData(rsData),
		.rtData(rtData),
		.aluOp(aluOp),
		.aluSrcImm(aluSrcImm),
		.signExt(signExt),
		.branchEq(branchEq),
		.branchNe(branchNe),
		.aluResult(aluResult),
		.takeBranch(takeBranch),
		.branchTarget(branchTarget)
	);

endmodule

`default_nettype wire

/* verilog/executeUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module executeUnit (
	input wire cpuPkg::instrWordT instr,
	input wire logic [cpuPkg::xlen-1:0] pc,
	input wire logic [cpuPkg::xlen-1:0] rsData,
	input wire logic [cpuPkg::xlen-1:0] rtData,
	input wire logic [cpuPkg::aluOpW-1:0] aluOp,
	input wire logic aluSrcImm,
	input wire logic signExt,
	input wire logic branchEq,
	input wire logic branchNe,
	output logic [cpuPkg::xlen-1:0] aluResult,
	output logic takeBranch,
	output logic [cpuPkg::xlen-1:0] branchTarget
);
	import cpuPkg::*;

	logic [xlen-1:0] immSext;
	logic [xlen-1:0] immExt;
	logic [xlen-1:0] opA;
	logic [xlen-1:0] opB;
	logic [xlen-1:0] pcPlus4;
	logic zero;

	assign immSext = {{(xlen-16){instr.iType.imm[15]}}, instr.iType.imm};
	assign immExt = signExt ? immSext : {{(xlen-16){1'b0}}, instr.iType.imm};

	// SLL shifts rt by shamt and ignores rs
	always_comb begin
		if (aluOp == aluSll) begin
			opA = rtData;
			opB = {{(xlen-5){1'b0}}, instr.rType.shamt};
		end else begin
			opA = rsData;
			opB = aluSrcImm ? immExt : rtData;
		end
	end

	always_comb begin
		case (aluOp)
			aluAnd: aluResult = opA & opB;
			aluOr: aluResult = opA | opB;
			aluAdd: aluResult = opA + opB;
			aluNor: aluResult = ~(opA | opB);
			aluXor: aluResult = opA ^ opB;
			aluSub: aluResult = opA - opB;
			aluSlt: begin
				aluResult = {{(xlen-1){1'b0}}, $signed(opA) < $signed(opB)};
			end
			aluSll: aluResult = opA << opB[4:0];
			aluLui: aluResult = {opB[15:0], 16'h0000}; // Imm to upper half
			default: aluResult = '0;
		endcase
	end

	assign zero = (aluResult == '0);
	assign takeBranch = (branchEq & zero) | (branchNe & ~zero);

	assign pcPlus4 = pc + 32'd4;
	assign branchTarget = pcPlus4 + {immSext[xlen-3:0], 2'b00}; // Word offset

endmodule

`default_nettype wire

/* verilog/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerFile (
	input wire logic clk,
	input wire logic rstN,
	input wire cpuPkg::instrWordT instr,
	input wire logic regDstRd,
	input wire logic regWe,
	input wire logic memToReg,
	input wire logic [cpuPkg::xlen-1:0] aluResult,
	input wire logic [cpuPkg::xlen-1:0] loadData,
	output logic [cpuPkg::xlen-1:0] rsData,
	output logic [cpuPkg::xlen-1:0] rtData
);
	import cpuPkg::*;

	logic [xlen-1:0] regs [2**regAddrW];
	logic [regAddrW-1:0] wrAddr;
	logic [xlen-1:0] wrData;

	assign wrAddr = regDstRd ? instr.rType.rd : instr.rType.rt;
	assign wrData = memToReg ? loadData : aluResult;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 2**regAddrW; i++) begin
				regs[i] <= '0;
			end
		end else if (regWe && wrAddr != '0) begin // $zero never written
			regs[wrAddr] <= wrData;
		end
	end

	assign rsData = (instr.rType.rs == '0) ? '0 : regs[instr.rType.rs];
	assign rtData = (instr.rType.rt == '0) ? '0 : regs[instr.rType.rt];

endmodule

`default_nettype wire

/* verilog/controlDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module controlDecoder (
	input wire cpuPkg::instrWordT instr,
	output logic [cpuPkg::aluOpW-1:0] aluOp,
	output logic aluSrcImm,
	output logic signExt,
	output logic regDstRd,
	output logic regWe,
	output logic memToReg,
	output logic memWe,
	output logic branchEq,
	output logic branchNe,
	output logic jump
);
	import cpuPkg::*;

	always_comb begin
		aluOp = aluAnd;
		aluSrcImm = 1'b0;
		signExt = 1'b0;
		regDstRd = 1'b0;
		regWe = 1'b0;
		memToReg = 1'b0;
		memWe = 1'b0;
		branchEq = 1'b0;
		branchNe = 1'b0;
		jump = 1'b0;

		if (instr != '0) begin // All-zero word is a NOP
			case (instr.rType.opcode)
				opRType: begin
					regDstRd = 1'b1;
					regWe = 1'b1;
					case (instr.rType.funct)
						fnAdd, fnAddu: aluOp = aluAdd; // No overflow trap
						fnSub, fnSubu: aluOp = aluSub;
						fnAnd: aluOp = aluAnd;
						fnOr: aluOp = aluOr;
						fnXor: aluOp = aluXor;
						fnNor: aluOp = aluNor;
						fnSlt: aluOp = aluSlt;
						fnSll: aluOp = aluSll;
						default: begin
							regDstRd = 1'b0;
							regWe = 1'b0;
						end
					endcase
				end
				opAddi, opAddiu: begin
					aluOp = aluAdd;
					aluSrcImm = 1'b1;
					signExt = 1'b1;
					regWe = 1'b1;
				end
				opAndi: begin
					aluOp = aluAnd;
					aluSrcImm = 1'b1;
					regWe = 1'b1;
				end
				opOri: begin
					aluOp = aluOr;
					aluSrcImm = 1'b1;
					regWe = 1'b1;
				end
				opLui: begin
					aluOp = aluLui;
					aluSrcImm = 1'b1;
					regWe = 1'b1;
				end
				opLw: begin
					aluOp = aluAdd; // Base plus offset
					aluSrcImm = 1'b1;
					signExt = 1'b1;
					regWe = 1'b1;
					memToReg = 1'b1;
				end
				opSw: begin
					aluOp = aluAdd;
					aluSrcImm = 1'b1;
					signExt = 1'b1;
					memWe = 1'b1;
				end
				opBeq: begin
					aluOp = aluSub; // Compare via zero flag
					signExt = 1'b1;
					branchEq = 1'b1;
				end
				opBne: begin
					aluOp = aluSub;
					signExt = 1'b1;
					branchNe = 1'b1;
				end
				opJ: jump = 1'b1;
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/fetchUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchUnit (
	input wire logic clk,
	input wire logic rstN,
	input wire cpuPkg::instrWordT instr,
	input wire logic takeBranch,
	input wire logic [cpuPkg::xlen-1:0] branchTarget,
	input wire logic jump,
	output logic [cpuPkg::xlen-1:0] pc
);
	import cpuPkg::*;

	logic [xlen-1:0] pcPlus4;
	logic [xlen-1:0] jumpTarget;
	logic [xlen-1:0] nextPc;

	assign pcPlus4 = pc + 32'd4;
	assign jumpTarget = {pcPlus4[31:28], instr.jType.target, 2'b00}; // Stays in 256 MB region

	always_comb begin
		if (jump) begin
			nextPc = jumpTarget;
		end else if (takeBranch) begin
			nextPc = branchTarget;
		end else begin
			nextPc = pcPlus4;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= resetPc;
		end else begin
			pc <= nextPc;
		end
	end

endmodule

`default_nettype wire

/* verilog/cpuPkg.sv */
`default_nettype none

package cpuPkg;

	localparam int xlen = 32;
	localparam int regAddrW = 5;
	localparam int aluOpW = 4;

	// ALU operation codes
	localparam logic [aluOpW-1:0] aluAnd = 4'd0;
	localparam logic [aluOpW-1:0] aluOr = 4'd1;
	localparam logic [aluOpW-1:0] aluAdd = 4'd2;
	localparam logic [aluOpW-1:0] aluNor = 4'd3;
	localparam logic [aluOpW-1:0] aluXor = 4'd4;
	localparam logic [aluOpW-1:0] aluSub = 4'd6;
	localparam logic [aluOpW-1:0] aluSlt = 4'd7;
	localparam logic [aluOpW-1:0] aluLui = 4'd8;
	localparam logic [aluOpW-1:0] aluSll = 4'd10;

	// Primary opcodes in bits 31:26
	localparam logic [5:0] opRType = 6'd0;
	localparam logic [5:0] opJ = 6'd2;
	localparam logic [5:0] opBeq = 6'd4;
	localparam logic [5:0] opBne = 6'd5;
	localparam logic [5:0] opAddi = 6'd8;
	localparam logic [5:0] opAddiu = 6'd9;
	localparam logic [5:0] opAndi = 6'd12;
	localparam logic [5:0] opOri = 6'd13;
	localparam logic [5:0] opLui = 6'd15;
	localparam logic [5:0] opLw = 6'd35;
	localparam logic [5:0] opSw = 6'd43;

	// R-type function codes in bits 5:0
	localparam logic [5:0] fnSll = 6'd0;
	localparam logic [5:0] fnAdd = 6'd32;
	localparam logic [5:0] fnAddu = 6'd33;
	localparam logic [5:0] fnSub = 6'd34;
	localparam logic [5:0] fnSubu = 6'd35;
	localparam logic [5:0] fnAnd = 6'd36;
	localparam logic [5:0] fnOr = 6'd37;
	localparam logic [5:0] fnXor = 6'd38;
	localparam logic [5:0] fnNor = 6'd39;
	localparam logic [5:0] fnSlt = 6'd42;

	localparam logic [xlen-1:0] resetPc = 32'h0000_0000;

	typedef struct packed {
		logic [5:0] opcode;
		logic [regAddrW-1:0] rs;
		logic [regAddrW-1:0] rt;
		logic [regAddrW-1:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rTypeT;

	typedef struct packed {
		logic [5:0] opcode;
		logic [regAddrW-1:0] rs;
		logic [regAddrW-1:0] rt;
		logic [15:0] imm;
	} iTypeT;

	typedef struct packed {
		logic [5:0] opcode;
		logic [25:0] target;
	} jTypeT;

	// Same word in three field layouts
	typedef union packed {
		rTypeT rType;
		iTypeT iType;
		jTypeT jType;
	} instrWordT;

endpackage

`default_nettype wire
